// File: source/soc_consts.svh
// build-time sizes; KB_FIFO_DEPTH must be a power of two and SEG_FRAME_BITS must stay 64
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// scan-code queue
// pointers wrap freely, so keep this a power of two
`define KB_FIFO_DEPTH 8

// flops on ps2_clk and ps2_data before edge detect
// one more flop adds one cycle to the push latency
`define PS2_SYNC_LEN 3

// serial display timing
// one bit period is 2**SEG_DIV_W clk200m cycles
`define SEG_DIV_W 2

// eight digits of eight pattern bits
`define SEG_FRAME_BITS 64

// s_clk held low this long between frames
// marks the frame boundary for the receiver
`define SEG_GAP_CYCLES 16

`endif

// File: source/soc_pkg.sv
// types shared by the keyboard, controller and display blocks; no logic lives here
package soc_pkg;

    // one PS/2 scan code
    typedef logic [7:0] kb_code_t;

    // value on the display, digit 7 in the top nibble
    typedef logic [31:0] seg_word_t;

    // one digit, active low
    // bits 6..0 are segments g..a, bit 7 the decimal point
    typedef logic [7:0] seg_pat_t;

    // accepted key count, wraps at 32
    typedef logic [4:0] led_cnt_t;

    // PS/2 receiver
    typedef enum logic [1:0] {
        IDLE,
        DATA,
        PARITY,
        STOP
    } ps2_state_t;

    // display frame sequencer
    typedef enum logic {
        SHIFT,
        GAP
    } seg_state_t;

endpackage

// File: source/ps2_kbd.sv
// ps2_clk must be far slower than clk200m; bad frames vanish silently and overflow stays set until rst
`timescale 1ns/1ns
`include "soc_consts.svh"

module ps2_kbd (
    input  logic              clk200m,
    input  logic              rst,
    input  logic              ps2_clk,
    input  logic              ps2_data,
    input  logic              kb_rd,
    output soc_pkg::kb_code_t kb_data,
    output logic              kb_ready,
    output logic              overflow
);
    import soc_pkg::*;

    localparam int PTR_W = $clog2(`KB_FIFO_DEPTH);

    // line synchronizers, idle bus is high
    logic [`PS2_SYNC_LEN-1:0] clk_sync;
    logic [`PS2_SYNC_LEN-1:0] data_sync;
    logic                     clk_prev;
    logic                     clk_fall;
    logic                     bit_in;

    // frame assembly
    ps2_state_t               state;
    logic [2:0]               bit_cnt;
    kb_code_t                 shreg;
    logic                     push;

    // scan-code queue
    kb_code_t                 mem [`KB_FIFO_DEPTH];
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    logic [PTR_W:0]           count;
    logic                     full;
    logic                     do_wr;
    logic                     do_rd;

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            clk_sync  <= '1;
            data_sync <= '1;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[`PS2_SYNC_LEN-2:0], ps2_clk};
            data_sync <= {data_sync[`PS2_SYNC_LEN-2:0], ps2_data};
            clk_prev  <= clk_sync[`PS2_SYNC_LEN-1];
        end
    end

    // one-cycle strobe per falling ps2_clk
    assign clk_fall = clk_prev & ~clk_sync[`PS2_SYNC_LEN-1];
    // data has the same delay as the clock
    assign bit_in   = data_sync[`PS2_SYNC_LEN-1];

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            bit_cnt <= '0;
            push    <= 1'b0;
        end else begin
            push <= 1'b0;
            if (clk_fall) begin
                case (state)
                    // start bit must be 0
                    IDLE: begin
                        if (!bit_in) begin
                            state   <= DATA;
                            bit_cnt <= '0;
                        end
                    end
                    DATA: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= PARITY;
                        end
                    end
                    // odd parity over data plus parity bit
                    PARITY: begin
                        state <= (^{shreg, bit_in}) ? STOP : IDLE;
                    end
                    // stop bit must be 1, push goes out next cycle
                    STOP: begin
                        push  <= bit_in;
                        state <= IDLE;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // lsb first, so shift in from the top
    always_ff @(posedge clk200m) begin
        if (clk_fall && state == DATA) begin
            shreg <= {bit_in, shreg[7:1]};
        end
    end

    assign full  = (count == (PTR_W+1)'(`KB_FIFO_DEPTH));
    assign do_wr = push & ~full;
    assign do_rd = kb_rd & (count != '0);

    always_ff @(posedge clk200m) begin
        if (do_wr) begin
            mem[wr_ptr] <= shreg;
        end
    end

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{PTR_W{1'b0}}, do_wr} - {{PTR_W{1'b0}}, do_rd};
            // full queue drops the new code
            if (push && full) begin
                overflow <= 1'b1;
            end
        end
    end

    // oldest code, valid while kb_ready
    assign kb_data  = mem[rd_ptr];
    assign kb_ready = (count != '0);

    a_no_pop_empty: assert property (@(posedge clk200m) disable iff (rst)
        kb_rd |-> count != '0)
        else $error("ps2_kbd: pop while queue empty");

    a_drop_sets_ovf: assert property (@(posedge clk200m) disable iff (rst)
        push && full |=> overflow)
        else $error("ps2_kbd: dropped code did not set overflow");

endmodule

// File: source/seg_shift.sv
// drives a serial-load 8-digit display; seg_word is sampled only at frame start, so updates lag up to one frame
`timescale 1ns/1ns
`include "soc_consts.svh"

module seg_shift (
    input  logic               clk200m,
    input  logic               rst,
    input  soc_pkg::seg_word_t seg_word,
    output logic               s_clk,
    output logic               s_clrn,
    output logic               sout,
    output logic               seg_en
);
    import soc_pkg::*;

    localparam int DIGITS = `SEG_FRAME_BITS / 8;
    localparam int BIT_W  = $clog2(`SEG_FRAME_BITS);
    localparam int GAP_W  = $clog2(`SEG_GAP_CYCLES);

    seg_state_t                 state;
    logic [`SEG_DIV_W-1:0]      div_cnt;
    logic [BIT_W-1:0]           bit_cnt;
    logic [GAP_W-1:0]           gap_cnt;
    logic [`SEG_FRAME_BITS-1:0] shreg;
    logic [`SEG_FRAME_BITS-1:0] frame_pats;
    logic                       bit_end;
    logic                       frame_end;
    logic                       gap_end;
    logic                       run_q;

    // hex digit to active-low segments, decimal point off
    function automatic seg_pat_t hex2seg(input logic [3:0] nib);
        case (nib)
            4'h0: return 8'hc0;
            4'h1: return 8'hf9;
            4'h2: return 8'ha4;
            4'h3: return 8'hb0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hf8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'ha: return 8'h88;
            4'hb: return 8'h83;
            4'hc: return 8'hc6;
            4'hd: return 8'ha1;
            4'he: return 8'h86;
            default: return 8'h8e;
        endcase
    endfunction

    // digit 7 lands in the top byte and goes out first
    always_comb begin
        for (int i = 0; i < DIGITS; i++) begin
            frame_pats[i*8 +: 8] = hex2seg(seg_word[i*4 +: 4]);
        end
    end

    assign bit_end   = &div_cnt;
    assign frame_end = bit_end && (bit_cnt == BIT_W'(`SEG_FRAME_BITS - 1));
    assign gap_end   = (gap_cnt == GAP_W'(`SEG_GAP_CYCLES - 1));

    // reset parks on the last gap cycle so a frame loads at once
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            state   <= GAP;
            gap_cnt <= GAP_W'(`SEG_GAP_CYCLES - 1);
            div_cnt <= '0;
            bit_cnt <= '0;
            shreg   <= '1;
        end else begin
            case (state)
                SHIFT: begin
                    div_cnt <= div_cnt + 1'b1;
                    // shift as s_clk falls, ones fill behind
                    if (bit_end) begin
                        shreg   <= {shreg[`SEG_FRAME_BITS-2:0], 1'b1};
                        bit_cnt <= bit_cnt + 1'b1;
                        if (frame_end) begin
                            state   <= GAP;
                            gap_cnt <= '0;
                        end
                    end
                end
                default: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_end) begin
                        state   <= SHIFT;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        shreg   <= frame_pats;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // high half of each bit period, low through the gap
    assign s_clk  = (state == SHIFT) & div_cnt[`SEG_DIV_W-1];
    assign sout   = shreg[`SEG_FRAME_BITS-1];
    // display held cleared and blank while in reset
    assign s_clrn = run_q;
    assign seg_en = run_q;

    a_sout_stable: assert property (@(posedge clk200m) disable iff (rst)
        s_clk |-> $stable(sout))
        else $error("seg_shift: sout moved while s_clk high");

endmodule

// File: source/io_ctrl.sv
// stands in for CPU loads and stores; at most one pop every two cycles, and swt[7] stalls all pops
`timescale 1ns/1ns

module io_ctrl (
    input  logic               clk200m,
    input  logic               rst,
    input  logic [7:0]         swt,
    input  soc_pkg::kb_code_t  kb_data,
    input  logic               kb_ready,
    input  logic               overflow,
    output logic               kb_rd,
    output soc_pkg::seg_word_t seg_word,
    output logic [6:0]         leds
);
    import soc_pkg::*;

    // two-flop switch synchronizer
    logic [7:0] swt_meta;
    logic [7:0] swt_sync;
    logic       hold;
    logic       show_swt;

    // last four codes with the newest in the low byte
    seg_word_t  history;
    led_cnt_t   key_cnt;

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            swt_meta <= '0;
            swt_sync <= '0;
        end else begin
            swt_meta <= swt;
            swt_sync <= swt_meta;
        end
    end

    assign hold     = swt_sync[7];
    assign show_swt = swt_sync[0];

    // pop strobe one cycle after ready is seen
    // skips the cycle after a pop so ready has settled
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            kb_rd <= 1'b0;
        end else begin
            kb_rd <= kb_ready & ~hold & ~kb_rd;
        end
    end

    // code is valid during the pop cycle itself
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            history <= '0;
            key_cnt <= '0;
        end else if (kb_rd) begin
            history <= {history[23:0], kb_data};
            key_cnt <= key_cnt + 1'b1;
        end
    end

    // swt[0] picks switches or key history
    assign seg_word = show_swt ? {24'h000000, swt_sync} : history;

    // led map
    assign leds[4:0] = key_cnt;
    assign leds[5]   = swt_sync[5];
    assign leds[6]   = overflow;

    // pop only against a ready queue and never two in a row
    a_rd_ready: assert property (@(posedge clk200m) disable iff (rst)
        kb_rd |-> kb_ready && !$past(kb_rd))
        else $error("io_ctrl: pop without ready or back to back");

endmodule

// File: source/soc_top.sv
// board-level I/O only; no processor, everything on clk200m, leds[7] mirrors rst
`timescale 1ns/1ns

module soc_top (
    input  logic       clk200m,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    input  logic [7:0] swt,
    output logic [7:0] leds,
    output logic       seg_clk,
    output logic       seg_clr,
    output logic       seg_dt,
    output logic       seg_en
);
    import soc_pkg::*;

    // keyboard to controller
    kb_code_t   kb_data;
    logic       kb_ready;
    logic       kb_rd;
    logic       overflow;

    // controller to display and leds
    seg_word_t  seg_word;
    logic [6:0] io_leds;

    ps2_kbd u_ps2_kbd (
        .clk200m  (clk200m),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .kb_rd    (kb_rd),
        .kb_data  (kb_data),
        .kb_ready (kb_ready),
        .overflow (overflow)
    );

    io_ctrl u_io_ctrl (
        .clk200m  (clk200m),
        .rst      (rst),
        .swt      (swt),
        .kb_data  (kb_data),
        .kb_ready (kb_ready),
        .overflow (overflow),
        .kb_rd    (kb_rd),
        .seg_word (seg_word),
        .leds     (io_leds)
    );

    seg_shift u_seg_shift (
        .clk200m  (clk200m),
        .rst      (rst),
        .seg_word (seg_word),
        .s_clk    (seg_clk),
        .s_clrn   (seg_clr),
        .sout     (seg_dt),
        .seg_en   (seg_en)
    );

    // top led shows reset
    assign leds = {rst, io_leds};

endmodule

// File: tb/tb_tasks.svh
// tasks of tb_soc, included inside its module body; they use the tb signals, model and counters
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic report_error(input string msg);
    errors++;
    $display("error at %0t ns: %s", $time, msg);
endtask

// lit segments gfedcba, active high, for one hex digit
function automatic logic [6:0] lit_segments(input logic [3:0] nib);
    logic [6:0] lit [16];
    lit = '{7'b0111111, 7'b0000110, 7'b1011011, 7'b1001111,
            7'b1100110, 7'b1101101, 7'b1111101, 7'b0000111,
            7'b1111111, 7'b1101111, 7'b1110111, 7'b1111100,
            7'b0111001, 7'b1011110, 7'b1111001, 7'b1110001};
    return lit[nib];
endfunction

// pattern back to a digit; dp off, segments active low
task automatic decode_digit(input logic [7:0] pat, input int pos, output logic [3:0] nib);
    bit found;
    found = 1'b0;
    nib   = 4'hx;
    for (int v = 0; v < 16; v++) begin
        if (pat === {1'b1, ~lit_segments(4'(v))}) begin
            nib   = 4'(v);
            found = 1'b1;
        end
    end
    if (!found) begin
        errors++;
        $display("display digit %0d shows pattern %h, which is no hex digit", pos, pat);
    end
endtask

// one PS/2 frame: start, data lsb first, odd parity, stop
task automatic send_ps2(input kb_code_t code, input bit bad_parity);
    logic [10:0] frame;
    logic        par;
    par = ~^code;
    if (bad_parity) begin
        par = ~par;
    end
    frame = {1'b1, par, code, 1'b0};
    for (int i = 0; i < 11; i++) begin
        ps2_data = frame[i];
        repeat (PS2_HALF) @(negedge clk200m);
        ps2_clk = 1'b0;
        repeat (PS2_HALF) @(negedge clk200m);
        ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;
    repeat (PS2_IDLE) @(negedge clk200m);
endtask

// wait for a gap, then take the next 64 bits at s_clk rising
task automatic capture_frame(output logic [31:0] word);
    int          low_run;
    int          nbits;
    logic        prev_clk;
    logic [63:0] bits;
    logic [3:0]  nib;
    low_run = 0;
    while (low_run < GAP_SEEN) begin
        @(negedge clk200m);
        low_run = (seg_clk === 1'b0) ? low_run + 1 : 0;
    end
    prev_clk = 1'b0;
    nbits    = 0;
    bits     = '1;
    while (nbits < 64) begin
        @(negedge clk200m);
        if (seg_clk === 1'b1 && prev_clk === 1'b0) begin
            bits = {bits[62:0], seg_dt};
            nbits++;
        end
        prev_clk = seg_clk;
    end
    // digit 7 came first, so it sits in the top byte
    for (int d = 0; d < 8; d++) begin
        decode_digit(bits[d*8 +: 8], d, nib);
        word[d*4 +: 4] = nib;
    end
endtask

task automatic model_accept(input kb_code_t code);
    model_hist = '{model_hist[1], model_hist[2], model_hist[3], code};
    model_cnt  = model_cnt + 5'd1;
endtask

function automatic logic [31:0] model_word();
    return {model_hist[0], model_hist[1], model_hist[2], model_hist[3]};
endfunction

task automatic check_display(input logic [31:0] expected, input string what);
    logic [31:0] word;
    capture_frame(word);
    if (word !== expected) begin
        report_error($sformatf("%s: display %h, expected %h", what, word, expected));
    end
endtask

task automatic check_leds(input string what);
    if (leds[4:0] !== model_cnt) begin
        report_error($sformatf("%s: key count %0d, expected %0d", what, leds[4:0], model_cnt));
    end
    if (leds[6] !== model_ovf) begin
        report_error($sformatf("%s: overflow led %b, expected %b", what, leds[6], model_ovf));
    end
endtask

task automatic test_reset_state();
    model_hist = '{8'h00, 8'h00, 8'h00, 8'h00};
    model_cnt  = '0;
    model_ovf  = 1'b0;
    rst        = 1'b1;
    repeat (3) @(negedge clk200m);
    if (leds !== 8'h80) begin
        report_error($sformatf("leds in reset %h, expected 80", leds));
    end
    rst = 1'b0;
    @(negedge clk200m);
    if (leds !== 8'h00) begin
        report_error($sformatf("leds after reset %h, expected 00", leds));
    end
    if (seg_clr !== 1'b1 || seg_en !== 1'b1) begin
        report_error($sformatf("seg_clr=%b seg_en=%b after reset", seg_clr, seg_en));
    end
    check_display(32'h0, "reset");
endtask

task automatic test_single_key();
    kb_code_t code;
    code = 8'($urandom());
    send_ps2(code, 1'b0);
    model_accept(code);
    // one display frame
    repeat (FRAME_CYCLES) @(negedge clk200m);
    check_leds("single key");
    check_display(model_word(), "single key");
endtask

task automatic test_history();
    kb_code_t code;
    for (int i = 0; i < 5; i++) begin
        code = 8'($urandom());
        send_ps2(code, 1'b0);
        model_accept(code);
    end
    check_leds("history");
    check_display(model_word(), "history");
endtask

// bad frame must leave every register alone
task automatic test_parity_error();
    send_ps2(8'($urandom()), 1'b1);
    check_leds("parity error");
    check_display(model_word(), "parity error");
endtask

task automatic test_hold_overflow();
    kb_code_t burst [9];
    int       waited;
    led_cnt_t target;
    swt[7] = 1'b1;
    repeat (4) @(negedge clk200m);
    for (int i = 0; i < 9; i++) begin
        burst[i] = 8'($urandom());
        send_ps2(burst[i], 1'b0);
    end
    // queue holds eight, ninth code dropped
    model_ovf = 1'b1;
    check_leds("hold burst");
    target = model_cnt + 5'd8;
    swt[7] = 1'b0;
    waited = 0;
    while (leds[4:0] !== target && waited < DRAIN_LIMIT) begin
        @(negedge clk200m);
        waited++;
    end
    // settle, nothing more may pop
    repeat (8) @(negedge clk200m);
    for (int i = 0; i < 8; i++) begin
        model_accept(burst[i]);
    end
    check_leds("after hold");
    check_display(model_word(), "after hold");
endtask

task automatic test_switch_display();
    logic [7:0] sw;
    sw    = 8'($urandom());
    sw[0] = 1'b1;
    swt   = sw;
    repeat (4) @(negedge clk200m);
    if (leds[5] !== sw[5]) begin
        report_error($sformatf("leds[5] %b, expected swt[5] %b", leds[5], sw[5]));
    end
    check_display({24'h000000, sw}, "switch display");
    swt = 8'h00;
    repeat (4) @(negedge clk200m);
    check_display(model_word(), "back to history");
endtask

`endif

// File: tb/tb_soc.sv
// testbench for soc_top; directed tests on a fixed seed, run ends by itself at 20000 cycles
`timescale 1ns/1ns

module tb_soc;
    import soc_pkg::*;

    // ps2 bit half period and bus idle between frames, in clk200m cycles
    localparam int PS2_HALF       = 16;
    localparam int PS2_IDLE       = 32;
    // display frame: 64 bits of 4 cycles plus a 16 cycle gap
    localparam int FRAME_CYCLES   = 272;
    // longest s_clk low run inside a frame is 2 cycles
    localparam int GAP_SEEN       = 8;
    localparam int DRAIN_LIMIT    = 64;
    // ~16 frames of 384 cycles, 7 captures of up to 560, fixed waits, margin
    localparam int TIMEOUT_CYCLES = 20000;

    // DUT pins
    logic       clk200m;
    logic       rst;
    logic       ps2_clk;
    logic       ps2_data;
    logic [7:0] swt;
    logic [7:0] leds;
    logic       seg_clk;
    logic       seg_clr;
    logic       seg_dt;
    logic       seg_en;

    // reference model
    kb_code_t    model_hist [4];
    led_cnt_t    model_cnt;
    logic        model_ovf;

    int          errors;
    int          cycle_cnt;
    int          frames_seen;
    int          low_run_mon;
    logic        rst_q;

    soc_top dut_i (
        .clk200m  (clk200m),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .swt      (swt),
        .leds     (leds),
        .seg_clk  (seg_clk),
        .seg_clr  (seg_clr),
        .seg_dt   (seg_dt),
        .seg_en   (seg_en)
    );

    `include "tb_tasks.svh"

    always #20 clk200m = ~clk200m;

    // timeout guard
    always @(posedge clk200m) begin
        cycle_cnt <= cycle_cnt + 1;
        rst_q     <= rst;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // display monitor
    // counts gaps, and clear/enable must stay high once out of reset
    always @(negedge clk200m) begin
        if (seg_clk === 1'b0) begin
            low_run_mon <= low_run_mon + 1;
            if (low_run_mon == GAP_SEEN) begin
                frames_seen <= frames_seen + 1;
            end
        end else begin
            low_run_mon <= 0;
        end
        if (rst_q === 1'b0 && (seg_clr !== 1'b1 || seg_en !== 1'b1)) begin
            report_error($sformatf("seg_clr=%b seg_en=%b outside reset", seg_clr, seg_en));
        end
    end

    initial begin
        int unsigned seed;
        errors      = 0;
        cycle_cnt   = 0;
        frames_seen = 0;
        low_run_mon = 0;
        rst_q       = 1'b1;
        clk200m     = 1'b0;
        rst         = 1'b1;
        ps2_clk     = 1'b1;
        ps2_data    = 1'b1;
        swt         = 8'h00;
        seed        = $urandom(32'hfd9e);

        test_reset_state();
        test_single_key();
        test_history();
        test_parity_error();
        test_hold_overflow();
        test_switch_display();

        $display("errors: %0d, display frames seen: %0d", errors, frames_seen);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+source
+incdir+tb
source/soc_pkg.sv
source/ps2_kbd.sv
source/seg_shift.sv
source/io_ctrl.sv
source/soc_top.sv
tb/tb_soc.sv

// File: run.sh
#!/bin/sh
# build and run the soc testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_soc -o tb_soc_sim

status=0
./obj_dir/tb_soc_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
exit 0
